// File: bench/tb_i3c_ddr.sv
`timescale 1ns/1ps
`include "i3c_ddr_defines.svh"

module tb_i3c_ddr;

        localparam int MAX_WORDS = `I3C_DDR_MAX_WORDS;
        localparam int HALF      = `I3C_SCL_HALF_CYCLES;
        localparam int FRAME_MAX = 31 + 20 * MAX_WORDS;
        localparam int NUM_FRAMES = 10;

        logic        i_sys_clk;
        logic        i_sys_rst;
        logic        i_start;
        logic [6:0]  i_cmd_code;
        logic [6:0]  i_target_addr;
        logic [3:0]  i_word_count;
        logic [15:0] i_word_data = '0;
        logic        o_word_req;
        logic        o_scl;
        logic        o_sda;
        logic        o_busy;
        logic        o_done;

        int                   seed = 96;
        logic [15:0]          words [0:MAX_WORDS-1];
        logic [FRAME_MAX-1:0] exp_bits = '0;
        int                   exp_len = 0;
        int                   cur_n = 0;

        // bus monitor counts, cleared before each frame starts
        int   toggles = 0;
        int   sda_falls = 0;
        int   done_count = 0;
        int   req_count = 0;
        logic prev_scl = 1'b1;
        logic prev_sda = 1'b1;
        logic prev_busy = 1'b0;
        int   idx_q [$];
        logic bit_q [$];

        i3c_ddr_top u_dut (
                .i_sys_clk     (i_sys_clk),
                .i_sys_rst     (i_sys_rst),
                .i_start       (i_start),
                .i_cmd_code    (i_cmd_code),
                .i_target_addr (i_target_addr),
                .i_word_count  (i_word_count),
                .i_word_data   (i_word_data),
                .o_word_req    (o_word_req),
                .o_scl         (o_scl),
                .o_sda         (o_sda),
                .o_busy        (o_busy),
                .o_done        (o_done)
        );

        initial begin
                i_sys_clk = 1'b0;
                forever #4 i_sys_clk = ~i_sys_clk;
        end

        task automatic end_in_failure();
                $display("TEST FAIL");
                $fatal(1, "simulation stopped at the first error");
        endtask

        task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
                if (got !== exp) begin
                        $display("Mismatch at %0t ns: %s got %0h expected %0h",
                                 $time, name, got, exp);
                        end_in_failure();
                end
        endtask

        ////////////////////////////////////////////////////////////////////
        // reference model
        ////////////////////////////////////////////////////////////////////
        function automatic logic [i3c_ddr_frame_pkg::PAR_W-1:0] parity_of(input logic [15:0] pay);
                logic odd;
                logic even;
                odd  = 1'b0;
                even = 1'b1;
                for (int k = 1; k < 16; k += 2)
                        odd = odd ^ pay[k];
                for (int k = 0; k < 16; k += 2)
                        even = even ^ pay[k];
                return {odd, even};
        endfunction

        // one byte into the crc-5 of x^5 + x^2 + 1 msb first
        function automatic logic [i3c_ddr_frame_pkg::CRC_W-1:0] crc5_byte(
                        input logic [i3c_ddr_frame_pkg::CRC_W-1:0] crc_in,
                        input logic [7:0] data);
                logic [i3c_ddr_frame_pkg::CRC_W-1:0] crc;
                logic fb;
                crc = crc_in;
                for (int k = 7; k >= 0; k--) begin
                        fb  = crc[4] ^ data[k];
                        crc = {crc[3:0], 1'b0};
                        if (fb)
                                crc = crc ^ 5'b00101;
                end
                return crc;
        endfunction

        // bit 0 of the result is the first bit on the wire
        function automatic logic [FRAME_MAX-1:0] expected_frame(input logic [6:0] code,
                        input logic [6:0] addr, input int n);
                logic [FRAME_MAX-1:0]                bits;
                logic [15:0]                         pay;
                logic [19:0]                         wbits;
                logic [10:0]                         cbits;
                logic [i3c_ddr_frame_pkg::CRC_W-1:0] crc;
                int                                  pos;
                bits = '0;
                pos  = 0;
                crc  = `I3C_CRC5_SEED;
                // par_adj evens out bits 14,12..2 so PA0 ends up 1
                pay = {1'b0, code, addr, 1'b0};
                for (int k = 2; k <= 14; k += 2)
                        pay[0] = pay[0] ^ pay[k];
                wbits = {2'b01, pay, parity_of(pay)};
                for (int k = 19; k >= 0; k--) begin
                        bits[pos] = wbits[k];
                        pos++;
                end
                for (int w = 0; w < n; w++) begin
                        pay   = words[w];
                        wbits = {2'b10, pay, parity_of(pay)};
                        for (int k = 19; k >= 0; k--) begin
                                bits[pos] = wbits[k];
                                pos++;
                        end
                        crc = crc5_byte(crc, pay[15:8]);
                        crc = crc5_byte(crc, pay[7:0]);
                end
                cbits = {2'b01, `I3C_CRC_TOKEN, crc};
                for (int k = 10; k >= 0; k--) begin
                        bits[pos] = cbits[k];
                        pos++;
                end
                return bits;
        endfunction

        ////////////////////////////////////////////////////////////////////
        // bus monitor and word supply
        ////////////////////////////////////////////////////////////////////
        always @(negedge i_sys_clk) begin
                if (i_sys_rst) begin
                        if (o_word_req) begin
                                if (req_count >= cur_n) begin
                                        $display("too many o_word_req pulses for the word count");
                                        end_in_failure();
                                end else begin
                                        i_word_data = words[req_count];
                                        req_count++;
                                end
                        end
                        // the first toggle of a frame only launches bit 0
                        if (o_scl !== prev_scl) begin
                                if (toggles > 0) begin
                                        idx_q.push_back(toggles - 1);
                                        bit_q.push_back(prev_sda);
                                end
                                toggles++;
                        end
                        if (prev_scl && o_scl && prev_sda && !o_sda)
                                sda_falls++;
                        if (o_done) begin
                                done_count++;
                                check("o_busy", 32'(o_busy), 32'd0);
                                check("o_busy before o_done", 32'(prev_busy), 32'd1);
                        end
                end
                prev_scl  = o_scl;
                prev_sda  = o_sda;
                prev_busy = o_busy;
        end

        always @(posedge i_sys_clk) begin
                int   idx;
                logic b;
                while (idx_q.size() > 0) begin
                        idx = idx_q.pop_front();
                        b   = bit_q.pop_front();
                        if (idx >= exp_len) begin
                                $display("more bits were sampled than the frame holds");
                                end_in_failure();
                        end else begin
                                check($sformatf("o_sda bit %0d", idx), 32'(b), 32'(exp_bits[idx]));
                        end
                end
        end

        task automatic run_frame(input logic [6:0] code, input logic [6:0] addr, input int n,
                        input bit inject);
                int limit;
                int cyc;
                cur_n      = n;
                exp_len    = 31 + 20 * n;
                exp_bits   = expected_frame(code, addr, n);
                limit      = (exp_len + 16) * HALF + 64;
                toggles    = 0;
                sda_falls  = 0;
                done_count = 0;
                req_count  = 0;
                @(negedge i_sys_clk);
                i_cmd_code    = code;
                i_target_addr = addr;
                i_word_count  = 4'(n);
                i_start       = 1'b1;
                @(negedge i_sys_clk);
                i_start = 1'b0;
                check("o_busy", 32'(o_busy), 32'd1);
                if (inject) begin
                        cyc = 0;
                        while (toggles < 25 && cyc < limit) begin
                                @(negedge i_sys_clk);
                                cyc++;
                        end
                        if (toggles < 25) begin
                                $display("timeout waiting for the first data word");
                                end_in_failure();
                        end
                        // a start while busy must be ignored
                        i_cmd_code   = ~code;
                        i_word_count = 4'(MAX_WORDS);
                        i_start      = 1'b1;
                        @(negedge i_sys_clk);
                        i_start = 1'b0;
                end
                cyc = 0;
                while (done_count == 0 && cyc < limit) begin
                        @(negedge i_sys_clk);
                        cyc++;
                end
                if (done_count == 0) begin
                        $display("timeout waiting for o_done");
                        end_in_failure();
                end
                repeat (4 * HALF) @(negedge i_sys_clk);
                check("o_done pulses", done_count, 32'd1);
                check("o_word_req pulses", req_count, n);
                check("sampled bits", toggles - 1, exp_len);
                check("sda falls in exit", sda_falls, 32'd4);
                check("o_scl", 32'(o_scl), 32'd1);
                check("o_sda", 32'(o_sda), 32'd1);
                check("o_busy", 32'(o_busy), 32'd0);
        endtask

        initial begin
                logic [31:0] rnd;
                logic [6:0]  code;
                logic [6:0]  addr;
                int          n;
                i_sys_rst     = 1'b0;
                i_start       = 1'b0;
                i_cmd_code    = '0;
                i_target_addr = '0;
                i_word_count  = '0;
                repeat (3) @(negedge i_sys_clk);
                i_sys_rst = 1'b1;
                check("o_scl", 32'(o_scl), 32'd1);
                check("o_sda", 32'(o_sda), 32'd1);
                check("o_busy", 32'(o_busy), 32'd0);
                check("o_done", 32'(o_done), 32'd0);
                check("o_word_req", 32'(o_word_req), 32'd0);
                for (int f = 0; f < NUM_FRAMES; f++) begin
                        rnd  = $random(seed);
                        code = rnd[6:0];
                        addr = rnd[14:8];
                        rnd  = $random(seed);
                        n    = 1 + int'(rnd % 32'(MAX_WORDS));
                        // both ends of the word count come first
                        if (f == 0)
                                n = 1;
                        else if (f == 1)
                                n = MAX_WORDS;
                        for (int w = 0; w < MAX_WORDS; w++) begin
                                rnd      = $random(seed);
                                words[w] = rnd[15:0];
                        end
                        run_frame(code, addr, n, (f % 3) == 2);
                end
                $display("TEST PASS");
                $finish;
        end

endmodule

// File: compile.f
+incdir+include
src/i3c_ddr_frame_pkg.sv
src/i3c_ddr_ctrl_pkg.sv
src/i3c_tx_if.sv
src/i3c_scl_gen.sv
src/i3c_ddr_crc5.sv
src/i3c_ddr_tx.sv
src/i3c_ddr_frame_ctrl.sv
src/i3c_ddr_top.sv
bench/tb_i3c_ddr.sv

// File: include/i3c_ddr_defines.svh
`ifndef I3C_DDR_DEFINES_SVH
`define I3C_DDR_DEFINES_SVH

// frame size limit, word-count port is 4 bits
`define I3C_DDR_MAX_WORDS 8

// system clocks per scl half-period, minimum 4
`define I3C_SCL_HALF_CYCLES 4

// crc-5 start value and the token ahead of it
`define I3C_CRC5_SEED 5'h1F
`define I3C_CRC_TOKEN 4'hC

`endif

// File: run_sim.sh
#!/bin/sh
# build and run the i3c hdr-ddr testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -f "$LOG"

verilator --binary --timing --assert --top-module tb_i3c_ddr \
        -Mdir "$OBJ" -o sim_tb -f compile.f
if [ $? -ne 0 ]; then
        echo "verilator build failed"
        exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAIL" "$LOG"; then
        echo "simulation reported failure"
        exit 1
fi
if [ $status -ne 0 ]; then
        echo "simulation exited with status $status"
        exit 1
fi
exit 0

// File: src/i3c_ddr_crc5.sv
`timescale 1ns/1ps
`include "i3c_ddr_defines.svh"

module i3c_ddr_crc5 (
        input  logic                                i_sys_clk,
        input  logic                                i_sys_rst,
        input  logic                                i_clr,
        input  logic                                i_crc_en,
        input  logic [7:0]                          i_crc_byte,
        output logic [i3c_ddr_frame_pkg::CRC_W-1:0] o_crc_value
);

        localparam logic [i3c_ddr_frame_pkg::CRC_W-1:0] POLY = 5'h05;

        logic [i3c_ddr_frame_pkg::CRC_W-1:0] crc_next;

        // x^5 + x^2 + 1, eight bits per step, msb first
        always_comb begin
                logic fb;
                crc_next = o_crc_value;
                for (int i = 7; i >= 0; i--) begin
                        fb       = crc_next[4] ^ i_crc_byte[i];
                        crc_next = {crc_next[3:0], 1'b0} ^ (fb ? POLY : '0);
                end
        end

        always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
                if (!i_sys_rst)
                        o_crc_value <= `I3C_CRC5_SEED;
                else if (i_clr)
                        o_crc_value <= `I3C_CRC5_SEED;
                else if (i_crc_en)
                        o_crc_value <= crc_next;
        end

endmodule

// File: src/i3c_ddr_ctrl_pkg.sv
package i3c_ddr_ctrl_pkg;

        typedef enum logic [1:0] {
                TX_CMD_WORD  = 2'd0,
                TX_DATA_WORD = 2'd1,
                TX_CRC_WORD  = 2'd2,
                TX_EXIT      = 2'd3
        } tx_mode_e;

        typedef enum logic [2:0] {
                IDLE = 3'd0,
                CMD  = 3'd1,
                DATA = 3'd2,
                CRC  = 3'd3,
                EXIT = 3'd4
        } frame_state_e;

endpackage

// File: src/i3c_ddr_frame_ctrl.sv
`timescale 1ns/1ps
`include "i3c_ddr_defines.svh"

module i3c_ddr_frame_ctrl (
        input  logic        i_sys_clk,
        input  logic        i_sys_rst,
        input  logic        i_start,
        input  logic [6:0]  i_cmd_code,
        input  logic [6:0]  i_target_addr,
        input  logic [3:0]  i_word_count,
        input  logic [15:0] i_word_data,
        input  logic        i_half_tick,
        output logic        o_word_req,
        output logic        o_busy,
        output logic        o_done,
        output logic        o_scl_run,
        output logic        o_crc_clr,
        i3c_tx_if.ctrl      tx
);

        i3c_ddr_ctrl_pkg::frame_state_e  state;
        i3c_ddr_frame_pkg::ddr_payload_u cmd_word;
        i3c_ddr_frame_pkg::ddr_payload_u word_q;
        i3c_ddr_frame_pkg::ddr_payload_u word_buf;
        logic                            armed;
        logic                            fetch_q;
        logic [3:0]                      req_left;
        logic [3:0]                      data_left;
        logic                            accept;
        logic                            word_end;
        logic                            next_data;

        assign accept    = i_start && !o_busy;
        assign word_end  = tx.mode_done && ((state == i3c_ddr_ctrl_pkg::CMD) ||
                                            (state == i3c_ddr_ctrl_pkg::DATA));
        assign next_data = word_end && (data_left != '0);

        // par_adj makes the even-bit parity come out zero
        always_comb begin
                cmd_word                 = '0;
                cmd_word.cmd.cmd_code    = i_cmd_code;
                cmd_word.cmd.target_addr = i_target_addr;
                cmd_word.cmd.par_adj     = ^(cmd_word & 16'h5554);
        end

        ////////////////////////////////////////////////////////////////////
        // frame sequencer
        ////////////////////////////////////////////////////////////////////
        always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
                if (!i_sys_rst) begin
                        state      <= i3c_ddr_ctrl_pkg::IDLE;
                        armed      <= 1'b0;
                        fetch_q    <= 1'b0;
                        req_left   <= '0;
                        data_left  <= '0;
                        o_word_req <= 1'b0;
                        o_done     <= 1'b0;
                        o_crc_clr  <= 1'b0;
                end else begin
                        o_word_req <= 1'b0;
                        o_done     <= 1'b0;
                        o_crc_clr  <= accept;
                        fetch_q    <= o_word_req;
                        if (accept) begin
                                armed      <= 1'b1;
                                o_word_req <= 1'b1;
                                req_left   <= i_word_count - 1'b1;
                                data_left  <= i_word_count;
                        end
                        // start on a tick so scl stays high a full half-period first
                        if (armed && i_half_tick) begin
                                armed <= 1'b0;
                                state <= i3c_ddr_ctrl_pkg::CMD;
                        end
                        if (next_data) begin
                                state     <= i3c_ddr_ctrl_pkg::DATA;
                                data_left <= data_left - 1'b1;
                                if (req_left != '0) begin
                                        o_word_req <= 1'b1;
                                        req_left   <= req_left - 1'b1;
                                end
                        end else if (word_end) begin
                                state <= i3c_ddr_ctrl_pkg::CRC;
                        end
                        if (tx.mode_done && (state == i3c_ddr_ctrl_pkg::CRC))
                                state <= i3c_ddr_ctrl_pkg::EXIT;
                        if (tx.mode_done && (state == i3c_ddr_ctrl_pkg::EXIT)) begin
                                state  <= i3c_ddr_ctrl_pkg::IDLE;
                                o_done <= 1'b1;
                        end
                end
        end

        // prefetch buffer and current word
        always_ff @(posedge i_sys_clk) begin
                if (fetch_q)
                        word_buf <= i_word_data;
                if (accept)
                        word_q <= cmd_word;
                else if (next_data)
                        word_q <= word_buf;
        end

        always_comb begin
                case (state)
                i3c_ddr_ctrl_pkg::DATA: tx.mode = i3c_ddr_ctrl_pkg::TX_DATA_WORD;
                i3c_ddr_ctrl_pkg::CRC:  tx.mode = i3c_ddr_ctrl_pkg::TX_CRC_WORD;
                i3c_ddr_ctrl_pkg::EXIT: tx.mode = i3c_ddr_ctrl_pkg::TX_EXIT;
                default:                tx.mode = i3c_ddr_ctrl_pkg::TX_CMD_WORD;
                endcase
        end

        assign tx.tx_en  = (state != i3c_ddr_ctrl_pkg::IDLE);
        assign tx.word   = word_q;
        assign o_busy    = armed || (state != i3c_ddr_ctrl_pkg::IDLE);
        assign o_scl_run = tx.tx_en && (state != i3c_ddr_ctrl_pkg::EXIT);

        a_count_range: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
                accept |-> (i_word_count >= 4'd1) && (i_word_count <= `I3C_DDR_MAX_WORDS))
                else $error("word count out of range at start");

endmodule

// File: src/i3c_ddr_frame_pkg.sv
package i3c_ddr_frame_pkg;

        localparam int CRC_W = 5;
        localparam int PAR_W = 2;

        // command word, msb first
        typedef struct packed {
                logic       rnw;
                logic [6:0] cmd_code;
                logic [6:0] target_addr;
                logic       par_adj;
        } ddr_cmd_t;

        typedef struct packed {
                logic [7:0] byte_hi;
                logic [7:0] byte_lo;
        } ddr_data_t;

        // one 16-bit payload slot, decoded per word type
        typedef union packed {
                ddr_cmd_t  cmd;
                ddr_data_t data;
        } ddr_payload_u;

endpackage

// File: src/i3c_ddr_top.sv
`timescale 1ns/1ps

module i3c_ddr_top (
        input  logic        i_sys_clk,
        input  logic        i_sys_rst,
        input  logic        i_start,
        input  logic [6:0]  i_cmd_code,
        input  logic [6:0]  i_target_addr,
        input  logic [3:0]  i_word_count,
        input  logic [15:0] i_word_data,
        output logic        o_word_req,
        output logic        o_scl,
        output logic        o_sda,
        output logic        o_busy,
        output logic        o_done
);

        logic                                half_tick;
        logic                                scl_run;
        logic                                crc_clr;
        logic                                crc_en;
        logic [7:0]                          crc_byte;
        logic [i3c_ddr_frame_pkg::CRC_W-1:0] crc_value;

        i3c_tx_if u_tx_if ();

        i3c_scl_gen u_scl_gen (
                .i_sys_clk   (i_sys_clk),
                .i_sys_rst   (i_sys_rst),
                .i_run       (scl_run),
                .o_half_tick (half_tick),
                .o_scl       (o_scl)
        );

        i3c_ddr_crc5 u_crc5 (
                .i_sys_clk   (i_sys_clk),
                .i_sys_rst   (i_sys_rst),
                .i_clr       (crc_clr),
                .i_crc_en    (crc_en),
                .i_crc_byte  (crc_byte),
                .o_crc_value (crc_value)
        );

        i3c_ddr_tx u_tx (
                .i_sys_clk   (i_sys_clk),
                .i_sys_rst   (i_sys_rst),
                .i_half_tick (half_tick),
                .i_crc_value (crc_value),
                .o_crc_en    (crc_en),
                .o_crc_byte  (crc_byte),
                .o_sda       (o_sda),
                .tx          (u_tx_if.tx)
        );

        i3c_ddr_frame_ctrl u_frame_ctrl (
                .i_sys_clk     (i_sys_clk),
                .i_sys_rst     (i_sys_rst),
                .i_start       (i_start),
                .i_cmd_code    (i_cmd_code),
                .i_target_addr (i_target_addr),
                .i_word_count  (i_word_count),
                .i_word_data   (i_word_data),
                .i_half_tick   (half_tick),
                .o_word_req    (o_word_req),
                .o_busy        (o_busy),
                .o_done        (o_done),
                .o_scl_run     (scl_run),
                .o_crc_clr     (crc_clr),
                .tx            (u_tx_if.ctrl)
        );

endmodule

// File: src/i3c_ddr_tx.sv
`timescale 1ns/1ps
`include "i3c_ddr_defines.svh"

module i3c_ddr_tx (
        input  logic                                i_sys_clk,
        input  logic                                i_sys_rst,
        input  logic                                i_half_tick,
        input  logic [i3c_ddr_frame_pkg::CRC_W-1:0] i_crc_value,
        output logic                                o_crc_en,
        output logic [7:0]                          o_crc_byte,
        output logic                                o_sda,
        i3c_tx_if.tx                                tx
);

        // preamble, payload, parity
        localparam int FRAME_W = 2 + 16 + i3c_ddr_frame_pkg::PAR_W;
        localparam int CRC_PAD = FRAME_W - 2 - 4 - i3c_ddr_frame_pkg::CRC_W;

        logic [FRAME_W-1:0] frame_d;
        logic [FRAME_W-1:0] shreg;
        logic [4:0]         bit_cnt;
        logic [4:0]         last_bit;
        logic               pa1;
        logic               pa0;
        logic               launch;
        logic               load;
        logic               crc_pend;

        assign launch = tx.tx_en && i_half_tick;
        assign load   = launch && (bit_cnt == '0);

        // pa1 over odd bits, pa0 inverted over even bits
        assign pa1 = ^(tx.word & 16'hAAAA);
        assign pa0 = ~^(tx.word & 16'h5555);

        ////////////////////////////////////////////////////////////////////
        // word frame by mode
        ////////////////////////////////////////////////////////////////////
        always_comb begin
                case (tx.mode)
                i3c_ddr_ctrl_pkg::TX_CMD_WORD: begin
                        frame_d  = {2'b01, tx.word, pa1, pa0};
                        last_bit = 5'd19;
                end
                i3c_ddr_ctrl_pkg::TX_DATA_WORD: begin
                        frame_d  = {2'b10, tx.word, pa1, pa0};
                        last_bit = 5'd19;
                end
                i3c_ddr_ctrl_pkg::TX_CRC_WORD: begin
                        frame_d  = {2'b01, `I3C_CRC_TOKEN, i_crc_value, {CRC_PAD{1'b0}}};
                        last_bit = 5'd10;
                end
                default: begin
                        // closing half-period high, then four low/high pairs
                        frame_d  = {9'b1_0101_0101, {(FRAME_W - 9){1'b0}}};
                        last_bit = 5'd8;
                end
                endcase
        end

        always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
                if (!i_sys_rst) begin
                        o_sda        <= 1'b1;
                        bit_cnt      <= '0;
                        tx.mode_done <= 1'b0;
                        o_crc_en     <= 1'b0;
                        crc_pend     <= 1'b0;
                end else begin
                        tx.mode_done <= 1'b0;
                        if (launch) begin
                                o_sda <= (bit_cnt == '0) ? frame_d[FRAME_W-1] : shreg[FRAME_W-1];
                                if (bit_cnt == last_bit) begin
                                        bit_cnt      <= '0;
                                        tx.mode_done <= 1'b1;
                                end else begin
                                        bit_cnt <= bit_cnt + 1'b1;
                                end
                        end
                        // two bytes per data word, hi then lo
                        crc_pend <= load && (tx.mode == i3c_ddr_ctrl_pkg::TX_DATA_WORD);
                        o_crc_en <= crc_pend ||
                                    (load && (tx.mode == i3c_ddr_ctrl_pkg::TX_DATA_WORD));
                end
        end

        always_ff @(posedge i_sys_clk) begin
                if (load)
                        shreg <= frame_d << 1;
                else if (launch)
                        shreg <= shreg << 1;
                if (crc_pend)
                        o_crc_byte <= tx.word.data.byte_lo;
                else
                        o_crc_byte <= tx.word.data.byte_hi;
        end

        a_done_in_frame: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
                tx.mode_done |-> tx.tx_en)
                else $error("mode_done outside an active frame");

endmodule

// File: src/i3c_scl_gen.sv
`timescale 1ns/1ps
`include "i3c_ddr_defines.svh"

module i3c_scl_gen (
        input  logic i_sys_clk,
        input  logic i_sys_rst,
        input  logic i_run,
        output logic o_half_tick,
        output logic o_scl
);

        localparam int HALF_CYCLES = `I3C_SCL_HALF_CYCLES;
        localparam int CNT_W       = $clog2(HALF_CYCLES);

        logic [CNT_W-1:0] cnt;

        assign o_half_tick = (cnt == '0);

        always_ff @(posedge i_sys_clk or negedge i_sys_rst) begin
                if (!i_sys_rst) begin
                        cnt   <= CNT_W'(HALF_CYCLES - 1);
                        o_scl <= 1'b1;
                end else begin
                        if (o_half_tick)
                                cnt <= CNT_W'(HALF_CYCLES - 1);
                        else
                                cnt <= cnt - 1'b1;
                        // stopped: only a low scl still toggles, so it parks high
                        if (o_half_tick && (i_run || !o_scl))
                                o_scl <= ~o_scl;
                end
        end

        a_tick_single: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
                o_half_tick |=> !o_half_tick)
                else $error("half tick held for two cycles");

endmodule

// File: src/i3c_tx_if.sv
`timescale 1ns/1ps

interface i3c_tx_if;

        logic                            tx_en;
        i3c_ddr_ctrl_pkg::tx_mode_e      mode;
        i3c_ddr_frame_pkg::ddr_payload_u word;
        // one cycle, after the tick that launched the last bit
        logic                            mode_done;

        modport ctrl (
                output tx_en,
                output mode,
                output word,
                input  mode_done
        );

        modport tx (
                input  tx_en,
                input  mode,
                input  word,
                output mode_done
        );

endinterface
